//--- Makefile
VERILATOR = verilator
TOP       = tb_acq_station
FILELIST  = sim.f
FLAGS     = --binary --timing --assert
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- acq_station.sv
`timescale 1ns/1ps

module acq_station (
	input  logic       clock,
	input  logic       reset,
	input  logic       eoc,
	input  logic [7:0] data_in,
	input  logic       dsr,
	output logic       soc,
	output logic       load_dato,
	output logic       mux_en,
	output logic [3:0] canale,
	output logic       add_mpx2,
	output logic       data_out,
	output logic       error
);

	logic [station_pkg::CHAN_W-1:0]   chan;

	// sequencer to buffer
	logic                             in_valid;
	logic                             in_ready;
	logic [station_pkg::CHAN_W-1:0]   in_chan;
	logic [station_pkg::SAMPLE_W-1:0] in_sample;

	// buffer to transmitter
	logic                             out_valid;
	logic                             out_ready;
	logic [station_pkg::CHAN_W-1:0]   out_chan;
	logic [station_pkg::SAMPLE_W-1:0] out_sample;

	// mux select pins, top bit unused by the eight inputs
	assign canale = {1'b0, chan};

	conv_sequencer u_seq (
		.clock     (clock),
		.reset     (reset),
		.eoc       (eoc),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.chan      (chan),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_chan   (in_chan),
		.in_sample (in_sample)
	);

	sample_fifo u_fifo (
		.clock      (clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_chan    (in_chan),
		.in_sample  (in_sample),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_chan   (out_chan),
		.out_sample (out_sample)
	);

	serial_tx u_tx (
		.clock      (clock),
		.reset      (reset),
		.dsr        (dsr),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_chan   (out_chan),
		.out_sample (out_sample),
		.data_out   (data_out),
		.add_mpx2   (add_mpx2),
		.error      (error)
	);

endmodule

//--- conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          eoc,
	input  logic [station_pkg::SAMPLE_W-1:0] data_in,
	output logic                          soc,
	output logic                          load_dato,
	output logic                          mux_en,
	output logic [station_pkg::CHAN_W-1:0]   chan,
	output logic                          in_valid,
	input  logic                          in_ready,
	output logic [station_pkg::CHAN_W-1:0]   in_chan,
	output logic [station_pkg::SAMPLE_W-1:0] in_sample
);

	station_pkg::seq_state_t state;

	// last channel before the counter wraps to zero
	localparam logic [station_pkg::CHAN_W-1:0] LAST_CHAN =
		station_pkg::CHAN_W'(station_pkg::NUM_CHANNELS - 1);

	// control path: state, converter handshake, channel counter, valid
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= station_pkg::seq_idle;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			mux_en    <= 1'b0;
			chan      <= '0;
			in_valid  <= 1'b0;
		end else begin
			case (state)
				station_pkg::seq_idle: begin
					// select the channel, mux needs a cycle to settle
					mux_en <= 1'b1;
					state  <= station_pkg::seq_mux_settle;
				end
				station_pkg::seq_mux_settle: begin
					soc   <= 1'b1;
					state <= station_pkg::seq_start_conv;
				end
				station_pkg::seq_start_conv: begin
					// soc is up, give the converter its first look at it
					state <= station_pkg::seq_wait_busy;
				end
				station_pkg::seq_wait_busy: begin
					// converter reports busy by raising eoc
					if (eoc) begin
						state <= station_pkg::seq_wait_done;
					end
				end
				station_pkg::seq_wait_done: begin
					// eoc falling means data_in now holds the result
					if (!eoc) begin
						load_dato <= 1'b1;
						state     <= station_pkg::seq_capture;
					end
				end
				station_pkg::seq_capture: begin
					load_dato <= 1'b0;
					in_valid  <= 1'b1;
					state     <= station_pkg::seq_offer;
				end
				station_pkg::seq_offer: begin
					// hold the pair until the buffer takes it
					if (in_ready) begin
						in_valid <= 1'b0;
						soc      <= 1'b0;
						mux_en   <= 1'b0;
						if (chan == LAST_CHAN) begin
							chan <= '0;
						end else begin
							chan <= chan + 1'b1;
						end
						state <= station_pkg::seq_idle;
					end
				end
				default: begin
					state <= station_pkg::seq_idle;
				end
			endcase
		end
	end

	// payload, latched while load_dato is high
	always_ff @(posedge clock) begin
		if (state == station_pkg::seq_capture) begin
			in_sample <= data_in;
			in_chan   <= chan;
		end
	end

	// the result is only latched while a conversion is open
	a_load_inside_soc: assert property (
		@(posedge clock) disable iff (reset)
		load_dato |-> soc
	) else $error("load_dato high without soc");

	// an offered pair stays up and unchanged until the buffer accepts it
	a_valid_held: assert property (
		@(posedge clock) disable iff (reset)
		(in_valid && !in_ready) |=> (in_valid && $stable(in_chan) && $stable(in_sample))
	) else $error("in_valid dropped or payload changed before transfer");

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  logic [station_pkg::CHAN_W-1:0]   in_chan,
	input  logic [station_pkg::SAMPLE_W-1:0] in_sample,
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic [station_pkg::CHAN_W-1:0]   out_chan,
	output logic [station_pkg::SAMPLE_W-1:0] out_sample
);

	localparam logic [station_pkg::PTR_W-1:0] LAST_PTR =
		station_pkg::PTR_W'(station_pkg::FIFO_DEPTH - 1);
	localparam logic [station_pkg::CNT_W-1:0] FULL_CNT =
		station_pkg::CNT_W'(station_pkg::FIFO_DEPTH);

	logic [station_pkg::CHAN_W-1:0]   chan_mem   [station_pkg::FIFO_DEPTH];
	logic [station_pkg::SAMPLE_W-1:0] sample_mem [station_pkg::FIFO_DEPTH];
	logic [station_pkg::PTR_W-1:0]    wr_ptr;
	logic [station_pkg::PTR_W-1:0]    rd_ptr;
	logic [station_pkg::CNT_W-1:0]    count;
	logic [station_pkg::CNT_W-1:0]    count_next;
	logic                             wr_en;
	logic                             rd_en;

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	// head of the queue goes straight out
	assign out_valid  = (count != '0);
	assign out_chan   = chan_mem[rd_ptr];
	assign out_sample = sample_mem[rd_ptr];

	// occupancy after this edge, a read and write together leave it alone
	always_comb begin
		count_next = count;
		if (wr_en && !rd_en) begin
			count_next = count + 1'b1;
		end else if (rd_en && !wr_en) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			in_ready <= 1'b0;
		end else begin
			count <= count_next;
			// ready comes from our own occupancy only
			in_ready <= (count_next < FULL_CNT);
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (wr_en) begin
			chan_mem[wr_ptr]   <= in_chan;
			sample_mem[wr_ptr] <= in_sample;
		end
	end

	// a full buffer only takes a word when the head leaves in the same edge
	a_no_overflow: assert property (
		@(posedge clock) disable iff (reset)
		wr_en |-> ((count != FULL_CNT) || rd_en)
	) else $error("write accepted into a full buffer");

endmodule

//--- serial_tx.sv
`timescale 1ns/1ps

module serial_tx (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          dsr,
	input  logic                          out_valid,
	output logic                          out_ready,
	input  logic [station_pkg::CHAN_W-1:0]   out_chan,
	input  logic [station_pkg::SAMPLE_W-1:0] out_sample,
	output logic                          data_out,
	output logic                          add_mpx2,
	output logic                          error
);

	localparam logic [station_pkg::BIT_CNT_W-1:0] LAST_CYCLE =
		station_pkg::BIT_CNT_W'(station_pkg::BIT_CYCLES - 1);
	localparam logic [station_pkg::BIT_IDX_W-1:0] LAST_BIT =
		station_pkg::BIT_IDX_W'(station_pkg::SAMPLE_W - 1);

	station_pkg::tx_state_t state;

	logic [station_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [station_pkg::BIT_IDX_W-1:0] bit_idx;
	logic [station_pkg::SAMPLE_W-1:0]  shift_reg;
	logic [station_pkg::SAMPLE_W-1:0]  sample_hold;
	// frame selector is high while the data frame is on the line
	logic                              data_frame;
	logic                              bit_end;

	assign add_mpx2 = data_frame;
	assign bit_end  = (bit_cnt == LAST_CYCLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= station_pkg::tx_idle;
			out_ready  <= 1'b0;
			data_out   <= 1'b1;
			error      <= 1'b0;
			data_frame <= 1'b0;
			bit_cnt    <= '0;
			bit_idx    <= '0;
		end else begin
			// bit period counter runs only while a frame is on the line
			if (state == station_pkg::tx_start_bit || state == station_pkg::tx_data_bits ||
					state == station_pkg::tx_stop_bit) begin
				bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
			end else begin
				bit_cnt <= '0;
			end
			case (state)
				station_pkg::tx_idle: begin
					if (out_valid && out_ready) begin
						out_ready <= 1'b0;
						state     <= station_pkg::tx_check_dsr;
					end else begin
						out_ready <= 1'b1;
					end
				end
				station_pkg::tx_check_dsr: begin
					// hold the pair and flag it while the receiver is not ready
					if (dsr) begin
						error    <= 1'b0;
						data_out <= 1'b0;
						state    <= station_pkg::tx_start_bit;
					end else begin
						error <= 1'b1;
					end
				end
				station_pkg::tx_start_bit: begin
					if (bit_end) begin
						data_out <= shift_reg[station_pkg::SAMPLE_W-1];
						bit_idx  <= '0;
						state    <= station_pkg::tx_data_bits;
					end
				end
				station_pkg::tx_data_bits: begin
					// msb first so the next bit always sits at the top of the shifter
					if (bit_end) begin
						if (bit_idx == LAST_BIT) begin
							data_out <= 1'b1;
							state    <= station_pkg::tx_stop_bit;
						end else begin
							data_out <= shift_reg[station_pkg::SAMPLE_W-1];
							bit_idx  <= bit_idx + 1'b1;
						end
					end
				end
				station_pkg::tx_stop_bit: begin
					if (bit_end) begin
						if (!data_frame) begin
							// header done and the data frame follows with no gap
							data_frame <= 1'b1;
							data_out   <= 1'b0;
							state      <= station_pkg::tx_start_bit;
						end else begin
							data_frame <= 1'b0;
							out_ready  <= 1'b1;
							state      <= station_pkg::tx_idle;
						end
					end
				end
				default: begin
					state <= station_pkg::tx_idle;
				end
			endcase
		end
	end

	// payload path loads the header byte first, then the held sample
	always_ff @(posedge clock) begin
		if (state == station_pkg::tx_idle && out_valid && out_ready) begin
			shift_reg <= {{(station_pkg::SAMPLE_W - station_pkg::CHAN_W){1'b0}}, out_chan};
			sample_hold <= out_sample;
		end else if (state == station_pkg::tx_stop_bit && bit_end && !data_frame) begin
			shift_reg <= sample_hold;
		end else if (bit_end && (state == station_pkg::tx_start_bit ||
				state == station_pkg::tx_data_bits)) begin
			shift_reg <= shift_reg << 1;
		end
	end

	// while held off nothing may be on the line
	a_error_quiet: assert property (
		@(posedge clock) disable iff (reset)
		error |-> (data_out && !(state inside {station_pkg::tx_start_bit,
			station_pkg::tx_data_bits, station_pkg::tx_stop_bit}))
	) else $error("error raised while a frame is being sent");

	a_mpx2_not_idle: assert property (
		@(posedge clock) disable iff (reset)
		add_mpx2 |-> (state != station_pkg::tx_idle)
	) else $error("add_mpx2 high in idle");

endmodule

//--- sim.f
station_pkg.sv
conv_sequencer.sv
sample_fifo.sv
serial_tx.sv
acq_station.sv
tb_acq_station.sv

//--- station_pkg.sv
package station_pkg;

	// converter result width
	localparam int SAMPLE_W = 8;

	// channel field width, plus the channel count on the analog mux
	localparam int CHAN_W = 3;
	localparam int NUM_CHANNELS = 8;

	// clock cycles per serial bit, shared with the testbench receiver
	localparam int BIT_CYCLES = 16;
	localparam int BIT_CNT_W = $clog2(BIT_CYCLES);

	// bit index inside one frame
	localparam int BIT_IDX_W = $clog2(SAMPLE_W);

	// sample buffer geometry
	localparam int FIFO_DEPTH = 2;
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// conversion sequencer states
	typedef enum logic [2:0] {
		seq_idle,
		seq_mux_settle,
		seq_start_conv,
		seq_wait_busy,
		seq_wait_done,
		seq_capture,
		seq_offer
	} seq_state_t;

	// serial transmitter states
	typedef enum logic [2:0] {
		tx_idle,
		tx_check_dsr,
		tx_start_bit,
		tx_data_bits,
		tx_stop_bit
	} tx_state_t;

endpackage

//--- tb_acq_station.sv
`timescale 1ns/1ps

module tb_acq_station;

	localparam int NUM_ROWS = 3;
	localparam int BIT_CYCLES = station_pkg::BIT_CYCLES;

	// each row holds a name and the converter value per channel (channel 0 in the low byte)
	// followed by the cycles with dsr low after reset and the pairs expected on the line
	string       row_name    [NUM_ROWS] = '{"order_wrap", "dsr_hold", "edge_values"};
	logic [63:0] row_vals    [NUM_ROWS] = '{64'h8877_6655_4433_2211, 64'h5a3c_e10f_7eb4_d296,
		64'h00ff_aa55_01fe_807f};
	int          row_dsr_low [NUM_ROWS] = '{0, 250, 0};
	int          row_pairs   [NUM_ROWS] = '{10, 6, 8};

	logic       clock;
	logic       reset;
	logic       eoc = 1'b0;
	logic [7:0] data_in = 8'h00;
	logic       dsr;
	logic       soc, load_dato, mux_en, add_mpx2, data_out, error;
	logic [3:0] canale;

	int          err_count = 0;
	int          tests_failed = 0;
	string       cur_name = "reset";
	int          cur_row = 0;
	int          cycles = 0;
	int          limit;
	logic [31:0] rng = 32'd77072;
	// converter model and load_dato monitor
	int          cv_phase, cv_wait, loads, soc_rises;
	bit          cv_loaded;
	// serial receiver
	bit          rx_busy;
	int          rx_slot, rx_tick, hdr_start;
	logic        rx_level, rx_frame_mpx;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_bytes [$];
	bit          rx_mpx [$];

	acq_station DUT (
		.clock(clock), .reset(reset), .eoc(eoc), .data_in(data_in), .dsr(dsr),
		.soc(soc), .load_dato(load_dato), .mux_en(mux_en), .canale(canale),
		.add_mpx2(add_mpx2), .data_out(data_out), .error(error)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("Mismatch %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
			err_count++;
		end
	endtask

	task automatic require(input bit cond, input string msg);
		assert (cond) else begin
			$display("Error in %s: %s", cur_name, msg);
			err_count++;
		end
	endtask

	task automatic expect_idle_outputs();
		require(!soc && !load_dato && !mux_en, "sequencer outputs not low after reset");
		require(!add_mpx2 && !error && data_out, "transmitter outputs not idle after reset");
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// run limit ends a hung run
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: no result after %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// converter answers soc after 1 to 6 cycles and holds eoc high for 1 to 4 cycles
	always @(negedge clock) begin
		if (reset) begin
			cv_phase = 0;
			eoc = 1'b0;
			loads = 0;
			soc_rises = 0;
		end else begin
			require(canale[3] == 1'b0, "canale bit 3 is set");
			// capture only after eoc went high then low and once per conversion
			if (load_dato) begin
				require(cv_phase == 3 && soc && !cv_loaded, "load_dato outside its conversion");
				cv_loaded = 1'b1;
				loads++;
			end
			case (cv_phase)
				0: if (soc) begin
					soc_rises++;
					cv_loaded = 1'b0;
					rng = xorshift(rng);
					cv_wait = 1 + int'(rng % 32'd6);
					cv_phase = 1;
				end
				1: begin
					cv_wait--;
					if (cv_wait == 0) begin
						eoc = 1'b1;
						rng = xorshift(rng);
						cv_wait = 1 + int'(rng % 32'd4);
						cv_phase = 2;
					end
				end
				2: begin
					cv_wait--;
					if (cv_wait == 0) begin
						eoc = 1'b0;
						data_in = row_vals[cur_row][int'(canale[2:0]) * 8 +: 8];
						cv_phase = 3;
					end
				end
				default: if (!soc) begin
					require(cv_loaded, "conversion closed without load_dato");
					cv_phase = 0;
				end
			endcase
		end
	end

	// receiver takes one slot per bit and the level must hold for the whole slot
	always @(negedge clock) begin
		if (reset) begin
			rx_busy = 1'b0;
			rx_bytes.delete();
			rx_mpx.delete();
		end else begin
			if (!rx_busy && !data_out) begin
				rx_busy = 1'b1;
				rx_slot = 0;
				rx_tick = 0;
				rx_frame_mpx = add_mpx2;
				// data frame follows its header back to back
				if (add_mpx2) begin
					compare_value("data frame start cycle", hdr_start + 10 * BIT_CYCLES, cycles);
				end else begin
					hdr_start = cycles;
				end
			end else if (!rx_busy) begin
				require(!add_mpx2, "add_mpx2 high between frames");
			end
			if (rx_busy) begin
				if (rx_tick == 0) begin
					rx_level = data_out;
				end else begin
					require(data_out == rx_level, "data_out changed inside a bit period");
				end
				require(add_mpx2 == rx_frame_mpx, "add_mpx2 changed inside a frame");
				if (rx_tick == BIT_CYCLES / 2) begin
					if (rx_slot == 0) begin
						require(!data_out, "start bit not low");
					end else if (rx_slot == 9) begin
						require(data_out, "stop bit not high");
					end else begin
						rx_shift = {rx_shift[6:0], data_out};
					end
				end
				if (rx_tick == BIT_CYCLES - 1) begin
					rx_tick = 0;
					if (rx_slot == 9) begin
						rx_bytes.push_back(rx_shift);
						rx_mpx.push_back(rx_frame_mpx);
						rx_busy = 1'b0;
					end else begin
						rx_slot++;
					end
				end else begin
					rx_tick++;
				end
			end
		end
	end

	initial begin
		int row_errs;
		int exp_chan;
		reset = 1'b1;
		dsr = 1'b1;
		limit = 0;
		// pair time on the line plus reset, dsr hold and conversion margin
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += row_pairs[r] * 20 * BIT_CYCLES + row_dsr_low[r] + 16 + 200;
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(negedge clock);
			cur_row = r;
			cur_name = row_name[r];
			row_errs = err_count;
			reset = 1'b1;
			dsr = (row_dsr_low[r] == 0);
			repeat (16) @(negedge clock);
			reset = 1'b0;
			while (!mux_en) begin
				expect_idle_outputs();
				@(negedge clock);
			end
			// pipeline fills up with one in tx, two buffer entries and one in the sequencer
			if (row_dsr_low[r] > 0) begin
				repeat (row_dsr_low[r]) @(negedge clock);
				require(error && data_out, "error not raised or line not idle while dsr low");
				require(!rx_busy && rx_bytes.size() == 0, "a frame started while dsr was low");
				require(soc_rises <= 4, "soc kept rising while dsr was low");
				dsr = 1'b1;
				@(negedge clock);
				require(!error && !data_out, "header did not start right after dsr returned");
			end
			while (rx_bytes.size() < 2 * row_pairs[r]) @(negedge clock);
			for (int i = 0; i < row_pairs[r]; i++) begin
				exp_chan = i % station_pkg::NUM_CHANNELS;
				compare_value("header byte", exp_chan, int'(rx_bytes[2 * i]));
				compare_value("data byte", int'(row_vals[r][exp_chan * 8 +: 8]),
					int'(rx_bytes[2 * i + 1]));
				require(!rx_mpx[2 * i] && rx_mpx[2 * i + 1], "add_mpx2 does not mark data frame");
			end
			// at most four samples captured but not yet on the line
			require(loads >= row_pairs[r] && loads <= row_pairs[r] + 4,
				"load_dato count does not match received pairs");
			if (err_count != row_errs) begin
				tests_failed++;
			end
			$display("%s pairs %0d errors %0d %s", cur_name, row_pairs[r],
				err_count - row_errs, (err_count == row_errs) ? "ok" : "failed");
		end
		$display("tests %0d, failed %0d, errors %0d", NUM_ROWS, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
